// ==== udp_pkg.sv ====
`default_nettype none

package udp_pkg;

  // UDP header is always 8 bytes
  localparam int UDP_HDR_LEN = 8;

  // IPv4 protocol number for UDP
  localparam logic [7:0] PROTO_UDP = 8'd17;

  // Width of a port number
  localparam int PORT_W = 16;

  // Header fields in wire order, src_port is the first word on the line
  typedef struct packed {
    logic [PORT_W-1:0] src_port;
    logic [PORT_W-1:0] dst_port;
    logic [15:0]       length;   // Header plus payload, in bytes
    logic [15:0]       chsum;
  } udp_hdr_t;

  // Same 64 bits seen as bytes or as fields
  // Byte 7 holds the first byte received, byte 0 the last
  typedef union packed {
    udp_hdr_t                    hdr;
    logic [UDP_HDR_LEN-1:0][7:0] raw;
  } udp_hdr_u;

  // 16-bit one's-complement add with end-around carry
  function automatic logic [15:0] oc_add16(
    input logic [15:0] a,
    input logic [15:0] b
  );
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]}; // Cannot carry out a second time
  endfunction

endpackage : udp_pkg

`default_nettype wire

// ==== udp_rx_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_parser (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic [7:0]                 in_dat,
  input  logic                       in_val,
  input  logic                       in_sof,
  input  logic                       in_eof,
  input  logic                       in_err,
  input  logic [7:0]                 in_proto,
  input  logic [15:0]                in_len,   // IP payload length
  output logic [7:0]                 pl_dat,
  output logic                       pl_val,
  output logic                       pl_sof,
  output logic                       pl_eof,
  output logic                       pl_err,
  output logic [udp_pkg::PORT_W-1:0] dst_port
);
  import udp_pkg::*;

  logic        frm_rst;   // Per-frame clear, high in the pl_eof cycle
  logic        receiving;
  logic        err_seen;
  logic [15:0] byte_cnt;  // Bytes taken so far in this datagram
  logic [15:0] udp_len;   // Length field from the header

  udp_hdr_u    hdr_q;
  udp_hdr_u    hdr_nxt;

  logic        sof_udp;
  logic        active;
  logic [15:0] idx;
  logic [15:0] cnt;
  logic [15:0] len_field;
  logic        bad;

  // A new datagram only starts on a UDP frame
  assign sof_udp = in_val && in_sof && (in_proto == PROTO_UDP);
  assign active  = (receiving && in_val) || sof_udp;

  assign idx = in_sof ? 16'd0 : byte_cnt; // Index of the byte on the bus
  assign cnt = idx + 16'd1;

  always_comb begin
    hdr_nxt.raw = {hdr_q.raw[UDP_HDR_LEN-2:0], in_dat};
  end

  // Length field is not latched yet when eof lands on the last header byte
  assign len_field = (idx == 16'(UDP_HDR_LEN - 1)) ? hdr_nxt.hdr.length : udp_len;

  assign bad = err_seen || in_err
            || (idx < 16'(UDP_HDR_LEN - 1))  // Shorter than a header
            || (cnt != len_field)
            || (cnt != in_len);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      frm_rst <= 1'b1;
    end else begin
      frm_rst <= active && in_eof;
    end
  end

  // Frame control
  always_ff @(posedge clk) begin
    if (fsm_rst || frm_rst) begin
      receiving <= 1'b0;
      err_seen  <= 1'b0;
      byte_cnt  <= 16'd0;
    end else begin
      if (active) begin
        byte_cnt <= cnt;
        if (in_eof) begin
          receiving <= 1'b0;
        end else if (in_sof) begin
          receiving <= 1'b1;
        end
      end
      if (sof_udp) begin
        err_seen <= in_err;
      end else if (receiving && in_err) begin
        err_seen <= 1'b1;
      end
    end
  end

  // Header shift register and field latch
  always_ff @(posedge clk) begin
    if (active && (idx < 16'(UDP_HDR_LEN))) begin
      hdr_q <= hdr_nxt;
    end
    if (active && (idx == 16'(UDP_HDR_LEN - 1))) begin
      dst_port <= hdr_nxt.hdr.dst_port;
      udp_len  <= hdr_nxt.hdr.length;
    end
    pl_dat <= in_dat;
  end

  // Payload strobes, one cycle behind the input
  always_ff @(posedge clk) begin
    if (fsm_rst || frm_rst) begin
      pl_val <= 1'b0;
      pl_sof <= 1'b0;
      pl_eof <= 1'b0;
      pl_err <= 1'b0;
    end else begin
      pl_val <= active && (idx >= 16'(UDP_HDR_LEN));
      pl_sof <= active && (idx == 16'(UDP_HDR_LEN));
      pl_eof <= active && in_eof;
      pl_err <= active && in_eof && bad;
    end
  end

  // Frame markers always ride on a valid byte
  a_mark_val: assert property (@(posedge clk) disable iff (fsm_rst)
    (in_sof || in_eof) |-> in_val);

  // Payload opens with pl_sof
  a_val_after_sof: assert property (@(posedge clk) disable iff (fsm_rst)
    $rose(pl_val) |-> pl_sof);

endmodule : udp_rx_parser

`default_nettype wire

// ==== udp_port_sink.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_port_sink #(
  parameter logic [udp_pkg::PORT_W-1:0] PORT = '0
) (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic [7:0]                 pl_dat,
  input  logic                       pl_val,
  input  logic                       pl_sof,
  input  logic                       pl_eof,
  input  logic                       pl_err,
  input  logic [udp_pkg::PORT_W-1:0] dst_port,
  output logic                       hit_done,
  output logic [15:0]                hit_bytes,
  output logic [15:0]                hit_sum
);
  import udp_pkg::*;

  logic        armed;
  logic        start;
  logic        in_frame;
  logic [15:0] bytes_q;
  logic [15:0] sum_q;
  logic [15:0] bytes_n;
  logic [15:0] sum_n;
  logic [15:0] word;

  // Lone pl_eof is a datagram without payload
  assign start = (pl_sof || (pl_eof && !pl_val && !armed)) && (dst_port == PORT);

  assign in_frame = start || armed;

  // Fresh totals on the first cycle of a datagram
  assign bytes_n = start ? 16'd0 : bytes_q;
  assign sum_n   = start ? 16'd0 : sum_q;

  // Even bytes go high, odd bytes low, so an odd tail is zero padded
  assign word = bytes_n[0] ? {8'h00, pl_dat} : {pl_dat, 8'h00};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      armed    <= 1'b0;
      hit_done <= 1'b0;
    end else begin
      hit_done <= in_frame && pl_eof && !pl_err;
      if (in_frame && pl_eof) begin
        armed <= 1'b0;
      end else if (start) begin
        armed <= 1'b1;
      end
    end
  end

  // Byte count and running sum
  always_ff @(posedge clk) begin
    if (in_frame) begin
      if (pl_val) begin
        bytes_q <= bytes_n + 16'd1;
        sum_q   <= oc_add16(sum_n, word);
      end else begin
        bytes_q <= bytes_n;
        sum_q   <= sum_n;
      end
    end
  end

  assign hit_bytes = bytes_q; // Final totals during hit_done
  assign hit_sum   = sum_q;

  // Parser keeps an idle gap between datagrams
  a_done_pulse: assert property (@(posedge clk) disable iff (fsm_rst)
    hit_done |=> !hit_done);

endmodule : udp_port_sink

`default_nettype wire

// ==== udp_report_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_report_merge #(
  parameter int N_PORTS = 4
) (
  input  logic                                         clk,
  input  logic                                         fsm_rst,
  input  logic [N_PORTS-1:0]                           hit_done,
  input  logic [N_PORTS-1:0][15:0]                     hit_bytes,
  input  logic [N_PORTS-1:0][15:0]                     hit_sum,
  output logic                                         rpt_val,
  output logic [$clog2(N_PORTS > 1 ? N_PORTS : 2)-1:0] rpt_port_idx,
  output logic [15:0]                                  rpt_bytes,
  output logic [15:0]                                  rpt_sum
);

  localparam int IDX_W = $clog2(N_PORTS > 1 ? N_PORTS : 2);

  logic [IDX_W-1:0] idx_c;
  logic [15:0]      bytes_c;
  logic [15:0]      sum_c;

  // At most one sink finishes per cycle
  always_comb begin
    idx_c   = '0;
    bytes_c = '0;
    sum_c   = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (hit_done[i]) begin
        idx_c   = IDX_W'(i);
        bytes_c = hit_bytes[i];
        sum_c   = hit_sum[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rpt_val <= 1'b0;
    end else begin
      rpt_val <= |hit_done;
    end
  end

  always_ff @(posedge clk) begin
    if (|hit_done) begin
      rpt_port_idx <= idx_c;
      rpt_bytes    <= bytes_c;
      rpt_sum      <= sum_c;
    end
  end

  // Two sinks on the same port would both fire here
  a_done_onehot: assert property (@(posedge clk) disable iff (fsm_rst)
    $onehot0(hit_done));

endmodule : udp_report_merge

`default_nettype wire

// ==== udp_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_stack #(
  parameter int                                       N_PORTS = 4,
  parameter logic [N_PORTS-1:0][udp_pkg::PORT_W-1:0] PORTS   =
    {16'd8080, 16'd5000, 16'd123, 16'd53}
) (
  input  logic                                         clk,
  input  logic                                         fsm_rst,
  input  logic [7:0]                                   in_dat,
  input  logic                                         in_val,
  input  logic                                         in_sof,
  input  logic                                         in_eof,
  input  logic                                         in_err,
  input  logic [7:0]                                   in_proto,
  input  logic [15:0]                                  in_len,
  output logic                                         rpt_val,
  output logic [$clog2(N_PORTS > 1 ? N_PORTS : 2)-1:0] rpt_port_idx,
  output logic [15:0]                                  rpt_bytes,
  output logic [15:0]                                  rpt_sum
);
  import udp_pkg::*;

  logic [7:0]              pl_dat;
  logic                    pl_val;
  logic                    pl_sof;
  logic                    pl_eof;
  logic                    pl_err;
  logic [PORT_W-1:0]       dst_port;

  logic [N_PORTS-1:0]      hit_done;
  logic [N_PORTS-1:0][15:0] hit_bytes;
  logic [N_PORTS-1:0][15:0] hit_sum;

  udp_rx_parser u_parser (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .in_dat   (in_dat),
    .in_val   (in_val),
    .in_sof   (in_sof),
    .in_eof   (in_eof),
    .in_err   (in_err),
    .in_proto (in_proto),
    .in_len   (in_len),
    .pl_dat   (pl_dat),
    .pl_val   (pl_val),
    .pl_sof   (pl_sof),
    .pl_eof   (pl_eof),
    .pl_err   (pl_err),
    .dst_port (dst_port)
  );

  // One sink per listening port
  for (genvar i = 0; i < N_PORTS; i++) begin : g_sink
    udp_port_sink #(
      .PORT (PORTS[i])
    ) u_sink (
      .clk       (clk),
      .fsm_rst   (fsm_rst),
      .pl_dat    (pl_dat),
      .pl_val    (pl_val),
      .pl_sof    (pl_sof),
      .pl_eof    (pl_eof),
      .pl_err    (pl_err),
      .dst_port  (dst_port),
      .hit_done  (hit_done[i]),
      .hit_bytes (hit_bytes[i]),
      .hit_sum   (hit_sum[i])
    );
  end

  udp_report_merge #(
    .N_PORTS (N_PORTS)
  ) u_merge (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .hit_done     (hit_done),
    .hit_bytes    (hit_bytes),
    .hit_sum      (hit_sum),
    .rpt_val      (rpt_val),
    .rpt_port_idx (rpt_port_idx),
    .rpt_bytes    (rpt_bytes),
    .rpt_sum      (rpt_sum)
  );

endmodule : udp_stack

`default_nettype wire

// ==== tb_udp_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_udp_stack;

  localparam int N_PORTS  = 4;
  localparam logic [N_PORTS-1:0][15:0] PORTS = {16'd7, 16'd443, 16'd2049, 16'd53};
  localparam int HDR_LEN  = 8;
  localparam int MAX_PL   = 40;
  localparam int N_DGRAMS = 200;
  localparam int TIMEOUT  = N_DGRAMS * (HDR_LEN + MAX_PL + 3 + 3) + 100;

  logic        clk = 1'b0; // Starts low without an edge at time zero
  logic        fsm_rst;
  logic [7:0]  in_dat;
  logic        in_val;
  logic        in_sof;
  logic        in_eof;
  logic        in_err;
  logic [7:0]  in_proto;
  logic [15:0] in_len;
  logic        rpt_val;
  logic [1:0]  rpt_port_idx;
  logic [15:0] rpt_bytes;
  logic [15:0] rpt_sum;

  logic [31:0] lfsr = 32'hb8e0fba4;
  logic [7:0]  frame [0:HDR_LEN+MAX_PL-1];
  int          errors;
  int          cyc;
  int          n_expected;
  int          n_reported;

  // Expected reports in arrival order
  int          due_q [$];
  int          id_q [$];
  logic [1:0]  idx_q [$];
  logic [15:0] bytes_q [$];
  logic [15:0] sum_q [$];

  udp_stack #(
    .N_PORTS (N_PORTS),
    .PORTS   (PORTS)
  ) uut (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .in_dat       (in_dat),
    .in_val       (in_val),
    .in_sof       (in_sof),
    .in_eof       (in_eof),
    .in_err       (in_err),
    .in_proto     (in_proto),
    .in_len       (in_len),
    .rpt_val      (rpt_val),
    .rpt_port_idx (rpt_port_idx),
    .rpt_bytes    (rpt_bytes),
    .rpt_sum      (rpt_sum)
  );

  always #2 clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Sum of big-endian words with the odd tail padded with zero
  function automatic logic [15:0] ones_sum(input int plen);
    logic [31:0] acc;
    acc = '0;
    for (int k = 0; k < plen; k++) begin
      if (k % 2 == 0) begin
        acc = acc + {16'd0, frame[HDR_LEN+k], 8'h00};
      end else begin
        acc = acc + {24'd0, frame[HDR_LEN+k]};
      end
    end
    while (acc[31:16] != 16'd0) begin
      acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
    end
    return acc[15:0];
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic send_datagram(input int id);
    int          plen;
    int          n;
    int          gap;
    int          err_pos;
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] len_field;
    logic [15:0] ip_len;
    logic [15:0] chk;
    logic [7:0]  proto;
    logic        err;
    logic        hit;
    logic        good;
    logic [1:0]  hit_idx;
    if (rand_bits(4) == 0) begin
      plen = 0;
    end else begin
      plen = int'(rand_bits(6) % (MAX_PL + 1));
    end
    n = HDR_LEN + plen;
    if (rand_bits(3) != 0) begin
      dst = PORTS[rand_bits(2)];
    end else begin
      dst = 16'(rand_bits(16)); // Most likely not listened to
    end
    src       = 16'(rand_bits(16));
    chk       = 16'(rand_bits(16));
    len_field = 16'(n);
    ip_len    = 16'(n);
    if (rand_bits(4) == 0) begin
      len_field = len_field ^ (16'd1 << rand_bits(4));
    end
    if (rand_bits(4) == 0) begin
      ip_len = ip_len ^ (16'd1 << rand_bits(4));
    end
    err     = (rand_bits(4) == 0);
    err_pos = int'(rand_bits(6)) % n;
    proto   = (rand_bits(4) == 0) ? 8'd6 : 8'd17; // TCP frames carry a UDP-like header

    frame[0] = src[15:8];
    frame[1] = src[7:0];
    frame[2] = dst[15:8];
    frame[3] = dst[7:0];
    frame[4] = len_field[15:8];
    frame[5] = len_field[7:0];
    frame[6] = chk[15:8];
    frame[7] = chk[7:0];
    for (int k = 0; k < plen; k++) begin
      frame[HDR_LEN+k] = 8'(rand_bits(8));
    end

    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (PORTS[i] == dst) begin
        hit     = 1'b1;
        hit_idx = 2'(i);
      end
    end
    good = hit && (proto == 8'd17) && !err && (len_field == 16'(n)) && (ip_len == 16'(n));

    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      in_dat <= frame[i];
      in_val <= 1'b1;
      in_sof <= (i == 0);
      in_eof <= (i == n - 1);
      in_err <= err && (i == err_pos);
      if (i == 0) begin
        in_proto <= proto;
        in_len   <= ip_len;
      end
      if ((i == n - 1) && good) begin
        due_q.push_back(cyc + 4); // Visible after the third edge past eof
        id_q.push_back(id);
        idx_q.push_back(hit_idx);
        bytes_q.push_back(16'(plen));
        sum_q.push_back(ones_sum(plen));
        n_expected++;
      end
    end

    gap = int'(rand_bits(2) % 3) + 1;
    repeat (gap) begin
      @(posedge clk);
      in_dat <= 8'h00;
      in_val <= 1'b0;
      in_sof <= 1'b0;
      in_eof <= 1'b0;
      in_err <= 1'b0;
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("Timeout: run still going after %0d cycles", cyc);
      $display("Some tests failed");
      $finish;
    end
  end

  // Outputs are sampled half a cycle after the edge
  always @(negedge clk) begin
    if (fsm_rst) begin
      if (rpt_val !== 1'b0) begin
        errors++;
        $display("rpt_val is not low during reset at cycle %0d", cyc);
      end
    end else if (rpt_val === 1'b1) begin
      if (due_q.size() == 0 || due_q[0] != cyc) begin
        errors++;
        $display("Unexpected rpt_val at cycle %0d", cyc);
      end else begin
        check_val($sformatf("dgram %0d rpt_port_idx", id_q[0]), {30'd0, idx_q[0]},
                  {30'd0, rpt_port_idx});
        check_val($sformatf("dgram %0d rpt_bytes", id_q[0]), {16'd0, bytes_q[0]},
                  {16'd0, rpt_bytes});
        check_val($sformatf("dgram %0d rpt_sum", id_q[0]), {16'd0, sum_q[0]},
                  {16'd0, rpt_sum});
        n_reported++;
        void'(due_q.pop_front());
        void'(id_q.pop_front());
        void'(idx_q.pop_front());
        void'(bytes_q.pop_front());
        void'(sum_q.pop_front());
      end
    end else if (rpt_val !== 1'b0) begin
      errors++;
      $display("rpt_val is unknown at cycle %0d", cyc);
    end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
      errors++;
      $display("Missing report for datagram %0d at cycle %0d", id_q[0], cyc);
      void'(due_q.pop_front());
      void'(id_q.pop_front());
      void'(idx_q.pop_front());
      void'(bytes_q.pop_front());
      void'(sum_q.pop_front());
    end
  end

  initial begin
    fsm_rst    = 1'b1;
    in_dat     = 8'h00;
    in_val     = 1'b0;
    in_sof     = 1'b0;
    in_eof     = 1'b0;
    in_err     = 1'b0;
    in_proto   = 8'd17;
    in_len     = 16'd0;
    errors     = 0;
    cyc        = 0;
    n_expected = 0;
    n_reported = 0;
    repeat (4) @(posedge clk);
    fsm_rst <= 1'b0;

    for (int d = 0; d < N_DGRAMS; d++) begin
      send_datagram(d);
    end

    wait (due_q.size() == 0);
    repeat (4) @(posedge clk); // A stray report would land within the latency
    @(negedge clk);
    $display("Errors: %0d, reports %0d of %0d expected, datagrams %0d",
             errors, n_reported, n_expected, N_DGRAMS);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_udp_stack

`default_nettype wire

// ==== flist.f ====
udp_pkg.sv
udp_rx_parser.sv
udp_port_sink.sv
udp_report_merge.sv
udp_stack.sv
tb_udp_stack.sv
